/* rtl/sca_target_pkg.sv */
/* SCA target shared definitions
   Sizes, host register map and the 4-bit PRESENT substitution table */

`default_nettype none

package sca_target_pkg;

  //////////////////////
  // Datapath sizes
  //////////////////////
  localparam int BlockW     = 32;                        // Cipher block and key
  localparam int NumRounds  = 8;                         // One round per cycle
  localparam int RoundCntW  = $clog2(NumRounds);
  localparam int StartDelay = 4;                         // Start to launch, in cycles
  localparam int DelayCntW  = $clog2(StartDelay + 1);

  // GPIO
  localparam int NumGpio        = 16;
  localparam int GpioIdxTrigger = 15;                    // Capture trigger pin

  //////////////////////
  // Host register map
  //////////////////////
  localparam int AddrW = 4;

  localparam logic [AddrW-1:0] RegKey     = AddrW'(0);
  localparam logic [AddrW-1:0] RegPlain   = AddrW'(1);
  localparam logic [AddrW-1:0] RegCtrl    = AddrW'(2); // [0] start, [1] trigger enable
  localparam logic [AddrW-1:0] RegStatus  = AddrW'(3); // [0] busy, [1] done
  localparam logic [AddrW-1:0] RegCipher  = AddrW'(4); // Read-only
  localparam logic [AddrW-1:0] RegGpioOut = AddrW'(5);
  localparam logic [AddrW-1:0] RegGpioOe  = AddrW'(6);
  localparam logic [AddrW-1:0] RegGpioIn  = AddrW'(7); // Read-only

  // PRESENT 4-bit S-box
  function automatic logic [3:0] sbox4(input logic [3:0] x);
    logic [3:0] y;
    case (x)
      4'h0: y = 4'hC;
      4'h1: y = 4'h5;
      4'h2: y = 4'h6;
      4'h3: y = 4'hB;
      4'h4: y = 4'h9;
      4'h5: y = 4'h0;
      4'h6: y = 4'hA;
      4'h7: y = 4'hD;
      4'h8: y = 4'h3;
      4'h9: y = 4'hE;
      4'hA: y = 4'hF;
      4'hB: y = 4'h8;
      4'hC: y = 4'h4;
      4'hD: y = 4'h7;
      4'hE: y = 4'h1;
      default: y = 4'h2;
    endcase
    return y;
  endfunction

endpackage : sca_target_pkg

`default_nettype wire

/* rtl/sca_ctrl.sv */
/* SCA target control block
   Four-phase host handshake, register file, read mux and start command */

`timescale 1ns/1ps
`default_nettype none

module sca_ctrl (
  input  wire logic                                  clk_main_i,
  input  wire logic                                  reset_i,
  // Host port
  input  wire logic                                  req_i,
  input  wire logic                                  we_i,
  input  wire logic [sca_target_pkg::AddrW-1:0]      addr_i,
  input  wire logic [sca_target_pkg::BlockW-1:0]     wdata_i,
  output logic                                       ack_o,
  output logic [sca_target_pkg::BlockW-1:0]          rdata_o,
  // Datapath status
  input  wire logic                                  busy_i,
  input  wire logic                                  done_i,
  input  wire logic                                  pending_i,
  input  wire logic [sca_target_pkg::BlockW-1:0]     cipher_i,
  input  wire logic [sca_target_pkg::NumGpio-1:0]    gpio_in_i,
  // Datapath control
  output logic [sca_target_pkg::BlockW-1:0]          key_o,
  output logic [sca_target_pkg::BlockW-1:0]          plain_o,
  output logic                                       trig_en_o,
  output logic                                       start_req_o,
  output logic [sca_target_pkg::NumGpio-1:0]         gpio_out_o,
  output logic [sca_target_pkg::NumGpio-1:0]         gpio_oe_o
);

  import sca_target_pkg::*;

  typedef enum logic {
    StIdle,                                   // Waiting for req
    StAck                                     // Ack high until req drops
  } hs_state_e;

  hs_state_e            state_q;
  logic                 access;               // One-cycle access strobe
  logic                 wr_en;
  logic                 active;               // Delay or run in progress
  logic [BlockW-1:0]    key_q, plain_q;
  logic [BlockW-1:0]    rdata_d, rdata_q;
  logic                 trig_en_q;
  logic                 start_req_q;
  logic [NumGpio-1:0]   gpio_out_q, gpio_oe_q;

  assign access = (state_q == StIdle) && req_i;
  assign wr_en  = access && we_i;
  assign active = busy_i || pending_i || start_req_q;

  ////////////////////
  // Handshake FSM
  ////////////////////
  always_ff @(posedge clk_main_i) begin
    if (reset_i) begin
      state_q     <= StIdle;
      trig_en_q   <= 1'b0;
      start_req_q <= 1'b0;
      gpio_out_q  <= '0;
      gpio_oe_q   <= '0;
    end else begin
      start_req_q <= 1'b0;                    // Single-cycle pulse
      case (state_q)
        StIdle: if (req_i) state_q <= StAck;
        default: if (!req_i) state_q <= StIdle;
      endcase
      if (wr_en) begin
        case (addr_i)
          RegCtrl: begin
            trig_en_q   <= wdata_i[1];
            start_req_q <= wdata_i[0] && !active; // Start refused when active
          end
          RegGpioOut: gpio_out_q <= wdata_i[NumGpio-1:0];
          RegGpioOe:  gpio_oe_q  <= wdata_i[NumGpio-1:0];
          default: ;
        endcase
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk_main_i) begin
    if (wr_en && addr_i == RegKey)   key_q   <= wdata_i;
    if (wr_en && addr_i == RegPlain) plain_q <= wdata_i;
    if (access)                      rdata_q <= rdata_d; // Held while ack high
  end

  ////////////////////
  // Read mux
  ////////////////////
  // Status reports the delay window as busy, old done hidden until the run ends
  always_comb begin
    case (addr_i)
      RegKey:     rdata_d = key_q;
      RegPlain:   rdata_d = plain_q;
      RegCtrl:    rdata_d = BlockW'({trig_en_q, 1'b0}); // Start reads as zero
      RegStatus:  rdata_d = BlockW'({done_i && !active, active});
      RegCipher:  rdata_d = cipher_i;
      RegGpioOut: rdata_d = BlockW'(gpio_out_q);
      RegGpioOe:  rdata_d = BlockW'(gpio_oe_q);
      RegGpioIn:  rdata_d = BlockW'(gpio_in_i);
      default:    rdata_d = '0;           // Unmapped
    endcase
  end

  assign ack_o       = (state_q == StAck);
  assign rdata_o     = rdata_q;
  assign key_o       = key_q;
  assign plain_o     = plain_q;
  assign trig_en_o   = trig_en_q;
  assign start_req_o = start_req_q;
  assign gpio_out_o  = gpio_out_q;
  assign gpio_oe_o   = gpio_oe_q;

  // Ack only follows a sampled request
  ack_after_req_a: assert property (@(posedge clk_main_i) disable iff (reset_i)
    $rose(ack_o) |-> $past(req_i));

  // No new start on top of a running cipher
  start_not_busy_a: assert property (@(posedge clk_main_i) disable iff (reset_i)
    start_req_o |-> !busy_i);

endmodule : sca_ctrl

`default_nettype wire

/* rtl/cipher_core.sv */
/* Toy SPN block cipher, one round per cycle
   Key schedule runs alongside the rounds with busy and done flags for status */

`timescale 1ns/1ps
`default_nettype none

module cipher_core (
  input  wire logic                              clk_main_i,
  input  wire logic                              reset_i,
  input  wire logic                              launch_i,
  input  wire logic [sca_target_pkg::BlockW-1:0] key_i,
  input  wire logic [sca_target_pkg::BlockW-1:0] plain_i,
  output logic                                   busy_o,
  output logic                                   done_o,
  output logic [sca_target_pkg::BlockW-1:0]      cipher_o
);

  import sca_target_pkg::*;

  logic [BlockW-1:0]    state_q;              // Cipher state
  logic [BlockW-1:0]    rkey_q;               // Current round key
  logic [BlockW-1:0]    cipher_q;
  logic [RoundCntW-1:0] round_q;
  logic                 busy_q, done_q;
  logic                 last_round;

  // Round datapath
  logic [BlockW-1:0]    mixed;                // After key add
  logic [BlockW-1:0]    subbed;               // After S-box layer
  logic [BlockW-1:0]    round_out;            // After rotation
  logic [BlockW-1:0]    rkey_next;

  assign last_round = (round_q == RoundCntW'(NumRounds - 1));

  ////////////////////
  // Round function
  ////////////////////
  always_comb begin
    mixed = state_q ^ rkey_q;
    for (int i = 0; i < BlockW / 4; i++) begin
      subbed[4*i +: 4] = sbox4(mixed[4*i +: 4]); // Nibble-wise substitution
    end
    // Rotate left by 5
    round_out = {subbed[BlockW-6:0], subbed[BlockW-1:BlockW-5]};
  end

  // Next round key is rotl 7 xor round index
  assign rkey_next = {rkey_q[BlockW-8:0], rkey_q[BlockW-1:BlockW-7]} ^ BlockW'(round_q);

  ////////////////////
  // Control
  ////////////////////
  always_ff @(posedge clk_main_i) begin
    if (reset_i) begin
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      round_q <= '0;
    end else if (launch_i) begin
      busy_q  <= 1'b1;
      done_q  <= 1'b0;                        // Cleared by the next start
      round_q <= '0;
    end else if (busy_q) begin
      round_q <= round_q + 1'b1;
      if (last_round) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  // Round state and key registers
  always_ff @(posedge clk_main_i) begin
    if (launch_i) begin
      state_q <= plain_i;
      rkey_q  <= key_i;
    end else if (busy_q) begin
      state_q <= round_out;
      rkey_q  <= rkey_next;
      if (last_round) begin
        cipher_q <= round_out ^ rkey_next; // Final whitening
      end
    end
  end

  assign busy_o   = busy_q;
  assign done_o   = done_q;
  assign cipher_o = cipher_q;

  // Launch is gated upstream by the pending and busy checks
  launch_not_busy_a: assert property (@(posedge clk_main_i) disable iff (reset_i)
    launch_i |-> !busy_o);

endmodule : cipher_core

`default_nettype wire

/* rtl/trigger_gate.sv */
/* Start delay and capture trigger gate
   Delays the start command and forwards the trigger only while the cipher runs */

`timescale 1ns/1ps
`default_nettype none

module trigger_gate (
  input  wire logic clk_main_i,
  input  wire logic reset_i,
  input  wire logic start_req_i,
  input  wire logic trig_en_i,
  input  wire logic busy_i,
  output logic      launch_o,
  output logic      pending_o,
  output logic      trig_o
);

  import sca_target_pkg::*;

  logic [DelayCntW-1:0] cnt_q;                // Cycles left until launch
  logic                 trig_q;

  ////////////////////
  // Start delay
  ////////////////////
  always_ff @(posedge clk_main_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (start_req_i) begin
      cnt_q <= DelayCntW'(StartDelay);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign launch_o  = (cnt_q == DelayCntW'(1)); // Last delay cycle
  assign pending_o = (cnt_q != '0);

  // Precise trigger, only while busy
  always_ff @(posedge clk_main_i) begin
    if (reset_i) trig_q <= 1'b0;
    else         trig_q <= trig_en_i & busy_i;
  end

  assign trig_o = trig_q;

endmodule : trigger_gate

`default_nettype wire

/* rtl/gpio_mux.sv */
/* GPIO output stage and input synchronizer
   Registers pin outputs and enables, pin 15 carries the capture trigger */

`timescale 1ns/1ps
`default_nettype none

module gpio_mux (
  input  wire logic                               clk_main_i,
  input  wire logic                               reset_i,
  input  wire logic [sca_target_pkg::NumGpio-1:0] gpio_out_i,
  input  wire logic [sca_target_pkg::NumGpio-1:0] gpio_oe_i,
  input  wire logic                               trig_i,
  input  wire logic [sca_target_pkg::NumGpio-1:0] gpio_i,
  output logic [sca_target_pkg::NumGpio-1:0]      gpio_o,
  output logic [sca_target_pkg::NumGpio-1:0]      gpio_oe_o,
  output logic [sca_target_pkg::NumGpio-1:0]      gpio_in_o
);

  import sca_target_pkg::*;

  localparam logic [NumGpio-1:0] TrigMask = NumGpio'(1) << GpioIdxTrigger;

  logic [NumGpio-1:0] out_d, oe_d;
  logic [NumGpio-1:0] out_q, oe_q;
  logic [NumGpio-1:0] sync1_q, sync2_q;      // Two-flop synchronizer

  ////////////////////
  // Output stage
  ////////////////////
  // Trigger pin overrides the register value
  always_comb begin
    out_d                 = gpio_out_i;
    out_d[GpioIdxTrigger] = trig_i;
    oe_d                  = gpio_oe_i | TrigMask; // Trigger pin always driven
  end

  always_ff @(posedge clk_main_i) begin
    if (reset_i) begin
      out_q <= '0;
      oe_q  <= TrigMask;                      // Pin 15 enabled out of reset
    end else begin
      out_q <= out_d;
      oe_q  <= oe_d;
    end
  end

  ////////////////////
  // Input sync
  ////////////////////
  always_ff @(posedge clk_main_i) begin
    if (reset_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= gpio_i;                      // Metastable stage
      sync2_q <= sync1_q;
    end
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign gpio_in_o = sync2_q;

endmodule : gpio_mux

`default_nettype wire

/* rtl/sca_target_top.sv */
/* SCA capture target top level
   Host control block, cipher, trigger gate and GPIO stage */

`timescale 1ns/1ps
`default_nettype none

module sca_target_top (
  input  wire logic                               clk_main_i,
  input  wire logic                               reset_i,
  // Host port
  input  wire logic                               req_i,
  input  wire logic                               we_i,
  input  wire logic [sca_target_pkg::AddrW-1:0]   addr_i,
  input  wire logic [sca_target_pkg::BlockW-1:0]  wdata_i,
  output logic                                    ack_o,
  output logic [sca_target_pkg::BlockW-1:0]       rdata_o,
  // Pins
  input  wire logic [sca_target_pkg::NumGpio-1:0] gpio_i,
  output logic [sca_target_pkg::NumGpio-1:0]      gpio_o,
  output logic [sca_target_pkg::NumGpio-1:0]      gpio_oe_o
);

  import sca_target_pkg::*;

  // Control to datapath
  logic [BlockW-1:0]  key, plain;
  logic               trig_en, start_req;
  logic [NumGpio-1:0] gpio_out, gpio_oe;

  // Datapath status
  logic               busy, done, pending, launch, trig;
  logic [BlockW-1:0]  cipher;
  logic [NumGpio-1:0] gpio_in;

  //////////////////////
  // Control block
  //////////////////////
  sca_ctrl u_ctrl (
    .clk_main_i  ( clk_main_i ),
    .reset_i     ( reset_i    ),
    .req_i       ( req_i      ),
    .we_i        ( we_i       ),
    .addr_i      ( addr_i     ),
    .wdata_i     ( wdata_i    ),
    .ack_o       ( ack_o      ),
    .rdata_o     ( rdata_o    ),
    .busy_i      ( busy       ),
    .done_i      ( done       ),
    .pending_i   ( pending    ),
    .cipher_i    ( cipher     ),
    .gpio_in_i   ( gpio_in    ),
    .key_o       ( key        ),
    .plain_o     ( plain      ),
    .trig_en_o   ( trig_en    ),
    .start_req_o ( start_req  ),
    .gpio_out_o  ( gpio_out   ),
    .gpio_oe_o   ( gpio_oe    )
  );

  //////////////////////
  // Datapath
  //////////////////////
  trigger_gate u_trig (
    .clk_main_i  ( clk_main_i ),
    .reset_i     ( reset_i    ),
    .start_req_i ( start_req  ),
    .trig_en_i   ( trig_en    ),
    .busy_i      ( busy       ),
    .launch_o    ( launch     ),
    .pending_o   ( pending    ),
    .trig_o      ( trig       )
  );

  cipher_core u_cipher (
    .clk_main_i  ( clk_main_i ),
    .reset_i     ( reset_i    ),
    .launch_i    ( launch     ),
    .key_i       ( key        ),
    .plain_i     ( plain      ),
    .busy_o      ( busy       ),
    .done_o      ( done       ),
    .cipher_o    ( cipher     )
  );

  // Pin 15 carries the capture trigger
  gpio_mux u_gpio (
    .clk_main_i  ( clk_main_i ),
    .reset_i     ( reset_i    ),
    .gpio_out_i  ( gpio_out   ),
    .gpio_oe_i   ( gpio_oe    ),
    .trig_i      ( trig       ),
    .gpio_i      ( gpio_i     ),
    .gpio_o      ( gpio_o     ),
    .gpio_oe_o   ( gpio_oe_o  ),
    .gpio_in_o   ( gpio_in    )
  );

endmodule : sca_target_top

`default_nettype wire

/* test/tb_sca_model.svh */
/* Testbench reference model
   Toy SPN cipher built on the PRESENT S-box, plus a shadow of the host register map */

`ifndef TB_SCA_MODEL_SVH
`define TB_SCA_MODEL_SVH

// PRESENT S-box, nibble i holds S(i)
localparam logic [63:0] PresentSboxTable = 64'h21748FE3DA09B65C;

// Shadow register map
logic [BlockW-1:0]  shadow_key;
logic [BlockW-1:0]  shadow_plain;
logic               shadow_trig_en;
logic [NumGpio-1:0] shadow_gpio_out;
logic [NumGpio-1:0] shadow_gpio_oe;
logic [NumGpio-1:0] shadow_gpio_in;           // Level held on the pins
logic [BlockW-1:0]  shadow_cipher;            // Last completed run
logic               shadow_done;

function automatic logic [3:0] sbox_lookup(input logic [3:0] x);
  return PresentSboxTable[4*int'(x) +: 4];
endfunction

function automatic logic [BlockW-1:0] rotate_left(input logic [BlockW-1:0] v, input int n);
  return (v << n) | (v >> (BlockW - n));
endfunction

// Key add, S-box layer, rotl 5; key schedule rotl 7 xor round index
function automatic logic [BlockW-1:0] model_encrypt(input logic [BlockW-1:0] key,
                                                    input logic [BlockW-1:0] plain);
  logic [BlockW-1:0] st;
  logic [BlockW-1:0] rk;
  logic [BlockW-1:0] subst;
  st = plain;
  rk = key;
  for (int r = 0; r < NumRounds; r++) begin
    st = st ^ rk;
    for (int n = 0; n < BlockW / 4; n++) begin
      subst[4*n +: 4] = sbox_lookup(st[4*n +: 4]);
    end
    st = rotate_left(subst, 5);
    rk = rotate_left(rk, 7) ^ BlockW'(r);
  end
  return st ^ rk;                             // Final whitening
endfunction

task automatic model_write(input logic [AddrW-1:0] a, input logic [BlockW-1:0] d);
  case (a)
    RegKey:     shadow_key      = d;
    RegPlain:   shadow_plain    = d;
    RegCtrl:    shadow_trig_en  = d[1];       // Start bit is not stored
    RegGpioOut: shadow_gpio_out = d[NumGpio-1:0];
    RegGpioOe:  shadow_gpio_oe  = d[NumGpio-1:0];
    default: ;                                // Read-only or unmapped
  endcase
endtask

// Expected read data while the cipher is idle
function automatic logic [BlockW-1:0] model_read(input logic [AddrW-1:0] a);
  case (a)
    RegKey:     return shadow_key;
    RegPlain:   return shadow_plain;
    RegCtrl:    return BlockW'({shadow_trig_en, 1'b0});
    RegStatus:  return BlockW'({shadow_done, 1'b0});
    RegCipher:  return shadow_cipher;
    RegGpioOut: return BlockW'(shadow_gpio_out);
    RegGpioOe:  return BlockW'(shadow_gpio_oe);
    RegGpioIn:  return BlockW'(shadow_gpio_in);
    default:    return '0;
  endcase
endfunction

`endif

/* test/tb_sca_target.sv */
/* Testbench for the SCA capture target
   Random host traffic checked against a reference model, plus trigger and GPIO checks */

`timescale 1ns/1ps
`default_nettype none

module tb_sca_target;

  import sca_target_pkg::*;

  localparam int ClkPeriod     = 8;
  localparam int ResetCycles   = 5;
  localparam int NumEncRuns    = 20;
  localparam int NumGpioRounds = 8;
  localparam int NumTestItems  = 10 + NumEncRuns + 4 + 2 + NumGpioRounds;
  localparam int WatchdogNs    = NumTestItems * (StartDelay + NumRounds + 40) * ClkPeriod;
  localparam int AckLimit      = 16;          // Cycles per handshake edge
  localparam int PollLimit     = 32;          // Status reads per run

  logic               clk_main;
  logic               reset;
  logic               req, we, ack;
  logic [AddrW-1:0]   addr;
  logic [BlockW-1:0]  wdata, rdata;
  logic [NumGpio-1:0] gpio_in, gpio_out, gpio_oe;

  int seed = 78536;
  int errors;
  int tests_passed;
  int tests_failed;
  int test_err_start;
  int trig_cycles;                            // Pin 15 high cycles in this run

  `include "tb_sca_model.svh"

  sca_target_top dut0 (
    .clk_main_i ( clk_main ),
    .reset_i    ( reset    ),
    .req_i      ( req      ),
    .we_i       ( we       ),
    .addr_i     ( addr     ),
    .wdata_i    ( wdata    ),
    .ack_o      ( ack      ),
    .rdata_o    ( rdata    ),
    .gpio_i     ( gpio_in  ),
    .gpio_o     ( gpio_out ),
    .gpio_oe_o  ( gpio_oe  )
  );

  initial begin
    clk_main = 1'b0;
    forever #(ClkPeriod / 2) clk_main = ~clk_main;
  end

  initial begin
    #(WatchdogNs);
    $display("Timeout: run did not finish within %0d ns", WatchdogNs);
    $display("Verification failed");
    $finish;
  end

  ////////////////////
  // Reporting
  ////////////////////
  task automatic report_mismatch(input string name, input logic [BlockW-1:0] exp,
                                 input logic [BlockW-1:0] act);
    $display("Mismatch %s: expected 0x%h, actual 0x%h", name, exp, act);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("Error: %s", msg);
    errors++;
  endtask

  task automatic begin_test();
    test_err_start = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == test_err_start) begin
      tests_passed++;
      $display("Test %s: PASS", name);
    end else begin
      tests_failed++;
      $display("Test %s: FAIL with %0d errors", name, errors - test_err_start);
    end
  endtask

  // Trigger pin watch on the falling edge
  always @(negedge clk_main) begin
    if (!reset) begin
      if (gpio_oe[GpioIdxTrigger] !== 1'b1) begin
        report_mismatch("gpio_oe_o[15]", BlockW'(1), BlockW'(gpio_oe[GpioIdxTrigger]));
      end
      if (gpio_out[GpioIdxTrigger] === 1'b1) trig_cycles++;
    end
  end

  ////////////////////
  // Host handshake
  ////////////////////
  task automatic host_access(input logic wr, input logic [AddrW-1:0] a,
                             input logic [BlockW-1:0] d, output logic [BlockW-1:0] rd);
    int waited;
    @(negedge clk_main);
    req   = 1'b1;
    we    = wr;
    addr  = a;
    wdata = d;
    waited = 0;
    do begin
      @(negedge clk_main);
      waited++;
    end while (ack !== 1'b1 && waited < AckLimit);
    if (ack !== 1'b1) report_failure("no ack while req was high");
    else if (waited != 1) report_failure("ack came later than one cycle after req");
    rd  = rdata;                              // Valid while ack high
    req = 1'b0;
    waited = 0;
    while (ack !== 1'b0 && waited < AckLimit) begin
      @(negedge clk_main);
      waited++;
    end
    if (ack !== 1'b0) report_failure("ack stayed high after req dropped");
    else if (waited != 1) report_failure("ack dropped later than one cycle after req fell");
  endtask

  task automatic host_write(input logic [AddrW-1:0] a, input logic [BlockW-1:0] d);
    logic [BlockW-1:0] rd;
    host_access(1'b1, a, d, rd);
    model_write(a, d);
  endtask

  task automatic host_read(input logic [AddrW-1:0] a, output logic [BlockW-1:0] rd);
    host_access(1'b0, a, '0, rd);
  endtask

  task automatic check_read(input string name, input logic [AddrW-1:0] a);
    logic [BlockW-1:0] rd;
    host_read(a, rd);
    if (rd !== model_read(a)) report_mismatch(name, model_read(a), rd);
  endtask

  // One cipher run, optionally with a second start while active
  task automatic run_cipher(input logic [BlockW-1:0] key, input logic [BlockW-1:0] plain,
                            input logic en, input logic restart);
    logic [BlockW-1:0] rd;
    logic [BlockW-1:0] expected;
    int polls;
    expected = model_encrypt(key, plain);
    host_write(RegKey, key);
    host_write(RegPlain, plain);
    trig_cycles = 0;
    host_write(RegCtrl, BlockW'({en, 1'b1}));
    if (restart) begin
      host_read(RegStatus, rd);
      if (rd[0] !== 1'b1) report_failure("status did not read busy after start");
      host_write(RegCtrl, BlockW'({en, 1'b1})); // Refused by the DUT
    end
    polls = 0;
    rd = '0;
    while (rd[1] !== 1'b1 && polls < PollLimit) begin
      host_read(RegStatus, rd);
      polls++;
    end
    if (rd[1] !== 1'b1) report_failure("status never reported done");
    else if (rd[0] !== 1'b0) report_mismatch("rdata_o status busy", '0, BlockW'(rd[0]));
    host_read(RegCipher, rd);
    if (rd !== expected) report_mismatch("rdata_o cipher", expected, rd);
    shadow_cipher = expected;
    shadow_done   = 1'b1;
    if (trig_cycles != (en ? NumRounds : 0)) begin
      report_mismatch("gpio_o[15] high cycles", BlockW'(en ? NumRounds : 0),
                      BlockW'(trig_cycles));
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////
  initial begin
    logic [NumGpio-1:0] exp_oe;
    reset   = 1'b1;
    req     = 1'b0;
    we      = 1'b0;
    addr    = '0;
    wdata   = '0;
    gpio_in = '0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    trig_cycles = 0;
    shadow_trig_en  = 1'b0;
    shadow_gpio_out = '0;
    shadow_gpio_oe  = '0;
    shadow_gpio_in  = '0;
    shadow_done     = 1'b0;
    exp_oe = '0;
    exp_oe[GpioIdxTrigger] = 1'b1;            // Trigger pin driven from reset
    repeat (ResetCycles) @(negedge clk_main);
    reset = 1'b0;

    // Register readback and reset values
    begin_test();
    @(negedge clk_main);
    if (ack !== 1'b0) report_mismatch("ack_o", '0, BlockW'(ack));
    if (gpio_out !== '0) report_mismatch("gpio_o", '0, BlockW'(gpio_out));
    if (gpio_oe !== exp_oe) report_mismatch("gpio_oe_o", BlockW'(exp_oe), BlockW'(gpio_oe));
    for (int i = 0; i < 3; i++) begin
      host_write(RegKey, $random(seed));
      host_write(RegPlain, $random(seed));
      host_write(RegGpioOut, $random(seed));
      host_write(RegGpioOe, $random(seed));
      check_read("rdata_o key", RegKey);
      check_read("rdata_o plain", RegPlain);
      check_read("rdata_o gpio_out", RegGpioOut);
      check_read("rdata_o gpio_oe", RegGpioOe);
    end
    check_read("rdata_o ctrl", RegCtrl);
    check_read("rdata_o status", RegStatus);
    for (int a = 8; a < 16; a++) begin
      host_write(AddrW'(a), $random(seed)); // Unmapped space reads zero
      check_read("rdata_o unmapped", AddrW'(a));
    end
    host_write(RegStatus, 32'hFFFF_FFFF);
    check_read("rdata_o status", RegStatus);
    host_write(RegGpioIn, $random(seed));
    check_read("rdata_o gpio_in", RegGpioIn);
    end_test("register readback");

    // Random encryptions with random trigger enable
    begin_test();
    for (int i = 0; i < NumEncRuns; i++) begin
      run_cipher($random(seed), $random(seed), 1'($random(seed)), 1'b0);
    end
    end_test("encryption");

    begin_test();
    for (int i = 0; i < 4; i++) begin
      run_cipher($random(seed), $random(seed), (i % 2) == 0, 1'b0);
      check_read("rdata_o ctrl", RegCtrl);
    end
    end_test("capture trigger");

    // Second start while active keeps one pulse and the same result
    begin_test();
    for (int i = 0; i < 2; i++) begin
      run_cipher($random(seed), $random(seed), 1'b1, 1'b1);
    end
    host_write(RegCipher, $random(seed));     // Read-only
    check_read("rdata_o cipher", RegCipher);
    host_write(RegStatus, 32'h0000_0000);
    check_read("rdata_o status", RegStatus);
    end_test("ignored start");

    begin_test();
    for (int i = 0; i < NumGpioRounds; i++) begin
      host_write(RegGpioOut, $random(seed));
      host_write(RegGpioOe, $random(seed));
      if (gpio_out[GpioIdxTrigger-1:0] !== shadow_gpio_out[GpioIdxTrigger-1:0]) begin
        report_mismatch("gpio_o", BlockW'(shadow_gpio_out[GpioIdxTrigger-1:0]),
                        BlockW'(gpio_out[GpioIdxTrigger-1:0]));
      end
      if (gpio_oe[GpioIdxTrigger-1:0] !== shadow_gpio_oe[GpioIdxTrigger-1:0]) begin
        report_mismatch("gpio_oe_o", BlockW'(shadow_gpio_oe[GpioIdxTrigger-1:0]),
                        BlockW'(gpio_oe[GpioIdxTrigger-1:0]));
      end
      if (gpio_out[GpioIdxTrigger] !== 1'b0) begin
        report_mismatch("gpio_o[15]", '0, BlockW'(gpio_out[GpioIdxTrigger]));
      end
      @(negedge clk_main);
      gpio_in = 16'($random(seed));
      shadow_gpio_in = gpio_in;
      repeat (3) @(negedge clk_main);         // Past the two-flop sync
      check_read("rdata_o gpio_in", RegGpioIn);
      check_read("rdata_o gpio_out", RegGpioOut);
      check_read("rdata_o gpio_oe", RegGpioOe);
    end
    end_test("gpio");

    $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule : tb_sca_target

`default_nettype wire

/* sca_target.f */
+incdir+test
rtl/sca_target_pkg.sv
rtl/sca_ctrl.sv
rtl/cipher_core.sv
rtl/trigger_gate.sv
rtl/gpio_mux.sv
rtl/sca_target_top.sv
test/tb_sca_target.sv

/* run_sim.sh */
#!/bin/sh
# Build the SCA target testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/1ps \
  --top-module tb_sca_target \
  -f sca_target.f \
  -o sim_sca_target

result="$(./obj_dir/sim_sca_target)"
echo "$result"

# Pass only when the testbench reports success
if echo "$result" | grep -q "Verification passed"; then
  exit 0
fi
exit 1
